// File: verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

    parameter int XLEN = 32;

    typedef enum logic [6:0] {
        OP_IMM   = 7'b0010011,
        OP_R3    = 7'b0110011,
        OP_LD    = 7'b0000011,
        OP_ST    = 7'b0100011,
        OP_BR    = 7'b1100011,
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_JAL   = 7'b1101111,
        OP_JALR  = 7'b1100111
    } opcode_e;

    // funct3 of OP_IMM and OP_R3
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } alu_f3_e;

    // funct3 of OP_BR
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } br_f3_e;

    // Seventeen operations, so one bit more than a nibble
    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B,
        ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

    // Encoded as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10
    } mem_size_e;

endpackage

`default_nettype wire

// File: verilog/ctrl_if.sv
`default_nettype none

interface ctrl_if;
    import rv_pkg::*;

    logic      reg_write;
    logic      pc_rs1_sel;            // Operand A is the PC (AUIPC)
    logic      imm_rs2_sel;           // Operand B is the immediate
    imm_fmt_e  imm_fmt;
    alu_op_e   alu_op;
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    logic      mem_write;
    logic      mem_read;
    mem_size_e mem_size;
    logic      load_unsigned;
    wb_sel_e   wb_sel;

    modport decoder (
        output reg_write, pc_rs1_sel, imm_rs2_sel, imm_fmt, alu_op, is_branch,
               is_jal, is_jalr, mem_write, mem_read, mem_size, load_unsigned, wb_sel
    );
    modport datapath (
        input reg_write, pc_rs1_sel, imm_rs2_sel, imm_fmt, alu_op, is_branch,
              is_jal, is_jalr, mem_write, mem_read, mem_size, load_unsigned, wb_sel
    );
    modport monitor (
        input reg_write, pc_rs1_sel, imm_rs2_sel, imm_fmt, alu_op, is_branch,
              is_jal, is_jalr, mem_write, mem_read, mem_size, load_unsigned, wb_sel
    );

endinterface

`default_nettype wire

// File: verilog/control_unit.sv
`default_nettype none

module control_unit (
    input  rv_pkg::opcode_e opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    ctrl_if.decoder         ctrl
);
    import rv_pkg::*;

    // Shared by OP_IMM and OP_R3, alt picks SUB or SRA
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: arith_op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     arith_op = ALU_SLL;
            F3_SLT:     arith_op = ALU_SLT;
            F3_SLTU:    arith_op = ALU_SLTU;
            F3_XOR:     arith_op = ALU_XOR;
            F3_SRL_SRA: arith_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      arith_op = ALU_OR;
            F3_AND:     arith_op = ALU_AND;
            default:    arith_op = ALU_ADD;
        endcase
    endfunction

    always_comb begin
        ctrl.reg_write     = 1'b0;    // Defaults keep the block latch free
        ctrl.pc_rs1_sel    = 1'b0;
        ctrl.imm_rs2_sel   = 1'b0;
        ctrl.imm_fmt       = IMM_I;
        ctrl.alu_op        = ALU_ADD;
        ctrl.is_branch     = 1'b0;
        ctrl.is_jal        = 1'b0;
        ctrl.is_jalr       = 1'b0;
        ctrl.mem_write     = 1'b0;
        ctrl.mem_read      = 1'b0;
        ctrl.mem_size      = SZ_WORD;
        ctrl.load_unsigned = 1'b0;
        ctrl.wb_sel        = WB_ALU;

        case (opcode)
            OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
                // funct7 holds immediate bits except on shifts right
                ctrl.alu_op      = arith_op(funct3, funct7[5] && funct3 == F3_SRL_SRA);
            end
            OP_R3: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = arith_op(funct3, funct7[5]);
            end
            OP_LD: begin
                ctrl.reg_write     = 1'b1;
                ctrl.imm_rs2_sel   = 1'b1;    // Address is rs1 + offset
                ctrl.mem_read      = 1'b1;
                ctrl.mem_size      = mem_size_e'(funct3[1:0]);
                ctrl.load_unsigned = funct3[2];
                ctrl.wb_sel        = WB_MEM;
            end
            OP_ST: begin
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.imm_fmt     = IMM_S;
                ctrl.mem_write   = 1'b1;
                ctrl.mem_size    = mem_size_e'(funct3[1:0]);
            end
            OP_BR: begin
                ctrl.imm_fmt   = IMM_B;
                ctrl.is_branch = 1'b1;
                case (funct3)
                    F3_BEQ:  ctrl.alu_op = ALU_EQ;
                    F3_BNE:  ctrl.alu_op = ALU_NE;
                    F3_BLT:  ctrl.alu_op = ALU_LT;
                    F3_BGE:  ctrl.alu_op = ALU_GE;
                    F3_BLTU: ctrl.alu_op = ALU_LTU;
                    F3_BGEU: ctrl.alu_op = ALU_GEU;
                    default: ctrl.is_branch = 1'b0;    // Reserved funct3
                endcase
            end
            OP_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.imm_fmt     = IMM_U;
                ctrl.alu_op      = ALU_PASS_B;
            end
            OP_AUIPC: begin
                ctrl.reg_write   = 1'b1;
                ctrl.pc_rs1_sel  = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.imm_fmt     = IMM_U;
            end
            OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.imm_fmt   = IMM_J;
                ctrl.is_jal    = 1'b1;
                ctrl.wb_sel    = WB_PC4;
            end
            OP_JALR: begin
                ctrl.reg_write   = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;    // Target is rs1 + offset
                ctrl.is_jalr     = 1'b1;
                ctrl.wb_sel      = WB_PC4;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/imm_gen.sv
`default_nettype none

module imm_gen (
    input  logic [rv_pkg::XLEN-1:0] instr,
    ctrl_if.datapath                ctrl,
    output logic [rv_pkg::XLEN-1:0] imm
);
    import rv_pkg::*;

    always_comb begin
        case (ctrl.imm_fmt)
            IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                          instr[11:8], 1'b0};
            IMM_U: imm = {instr[31:12], 12'b0};    // Upper 20 bits, low bits zero
            IMM_J: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                          instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`default_nettype none

module alu (
    ctrl_if.datapath                ctrl,
    input  logic [rv_pkg::XLEN-1:0] pc,
    input  logic [rv_pkg::XLEN-1:0] rs1_data,
    input  logic [rv_pkg::XLEN-1:0] rs2_data,
    input  logic [rv_pkg::XLEN-1:0] imm,
    output logic [rv_pkg::XLEN-1:0] result,
    output logic                    branch_taken
);
    import rv_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic            lt_s;
    logic            lt_u;
    logic            cond;

    assign op_a = ctrl.pc_rs1_sel ? pc : rs1_data;
    assign op_b = ctrl.imm_rs2_sel ? imm : rs2_data;
    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLL:    result = op_a << op_b[4:0];
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   result = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SRL:    result = op_a >> op_b[4:0];
            ALU_SRA:    result = $signed(op_a) >>> op_b[4:0];
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;                 // LUI
            default:    result = '0;                   // Branch compares
        endcase
    end

    // Branches always compare the two registers
    always_comb begin
        case (ctrl.alu_op)
            ALU_EQ:  cond = rs1_data == rs2_data;
            ALU_NE:  cond = rs1_data != rs2_data;
            ALU_LT:  cond = $signed(rs1_data) < $signed(rs2_data);
            ALU_GE:  cond = $signed(rs1_data) >= $signed(rs2_data);
            ALU_LTU: cond = rs1_data < rs2_data;
            ALU_GEU: cond = rs1_data >= rs2_data;
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = ctrl.is_branch & cond;

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`default_nettype none

module reg_file (
    input  logic                    clk,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [4:0]              rd,
    input  logic                    we,
    ctrl_if.datapath                ctrl,
    input  logic [rv_pkg::XLEN-1:0] alu_result,
    input  logic [rv_pkg::XLEN-1:0] load_data,
    input  logic [rv_pkg::XLEN-1:0] pc_plus4,
    output logic [rv_pkg::XLEN-1:0] rs1_data,
    output logic [rv_pkg::XLEN-1:0] rs2_data,
    output logic [rv_pkg::XLEN-1:0] wb_value
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  wb_value = load_data;
            WB_PC4:  wb_value = pc_plus4;    // Link address of JAL and JALR
            default: wb_value = alu_result;
        endcase
    end

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];    // x0 always reads zero
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0) begin
            regs[rd] <= wb_value;
        end
    end

endmodule

`default_nettype wire

// File: verilog/data_ram.sv
`default_nettype none

module data_ram #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                    clk,
    input  logic                    instr_valid,
    ctrl_if.datapath                ctrl,
    input  logic [rv_pkg::XLEN-1:0] addr,
    input  logic [rv_pkg::XLEN-1:0] store_data,
    output logic [rv_pkg::XLEN-1:0] load_data
);
    import rv_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    logic [XLEN-1:0] mem [DMEM_WORDS];
    logic [AW-1:0]   word_idx;
    logic [4:0]      lane_shift;
    logic [3:0]      byte_en;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;

    assign word_idx   = addr[AW+1:2];
    assign lane_shift = {addr[1:0], 3'b000};    // Byte offset in bits

    // Store path, lanes follow the low address bits
    always_comb begin
        case (ctrl.mem_size)
            SZ_BYTE: byte_en = 4'b0001 << addr[1:0];
            SZ_HALF: byte_en = 4'b0011 << {addr[1], 1'b0};
            default: byte_en = 4'b1111;
        endcase
    end

    assign wdata = store_data << lane_shift;

    always_ff @(posedge clk) begin
        if (instr_valid && ctrl.mem_write) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // Load path, addressed lane moved down to bit 0
    assign rdata = mem[word_idx] >> lane_shift;

    always_comb begin
        load_data = '0;
        if (ctrl.mem_read) begin
            case (ctrl.mem_size)
                SZ_BYTE: load_data = {{24{rdata[7] & ~ctrl.load_unsigned}}, rdata[7:0]};
                SZ_HALF: load_data = {{16{rdata[15] & ~ctrl.load_unsigned}}, rdata[15:0]};
                default: load_data = rdata;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/pc_unit.sv
`default_nettype none

module pc_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    ctrl_if.datapath                ctrl,
    input  logic [rv_pkg::XLEN-1:0] imm,
    input  logic [rv_pkg::XLEN-1:0] alu_result,
    input  logic                    branch_taken,
    output logic [rv_pkg::XLEN-1:0] pc,
    output logic [rv_pkg::XLEN-1:0] pc_plus4
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc_next;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        if (ctrl.is_jalr) begin
            pc_next = {alu_result[XLEN-1:1], 1'b0};    // rs1 + offset, bit 0 cleared
        end else if (branch_taken || ctrl.is_jal) begin
            pc_next = pc + imm;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (instr_valid) begin
            pc <= pc_next;                             // Holds while no instruction
        end
    end

endmodule

`default_nettype wire

// File: verilog/riscv_core.sv
`default_nettype none

module riscv_core #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [rv_pkg::XLEN-1:0] instr,
    input  logic                    instr_valid,
    output logic [rv_pkg::XLEN-1:0] pc,
    output logic                    wb_valid,
    output logic [4:0]              wb_rd,
    output logic [rv_pkg::XLEN-1:0] wb_data
);
    import rv_pkg::*;

    ctrl_if ctrl_bus ();

    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] alu_result;
    logic            branch_taken;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] pc_plus4;

    // Retirement trace, x0 targets never show
    assign wb_rd    = instr[11:7];
    assign wb_valid = instr_valid && ctrl_bus.reg_write && (wb_rd != 5'd0);

    control_unit u_control_unit (
        .opcode (opcode_e'(instr[6:0])),
        .funct3 (instr[14:12]),
        .funct7 (instr[31:25]),
        .ctrl   (ctrl_bus)
    );

    imm_gen u_imm_gen (
        .instr (instr),
        .ctrl  (ctrl_bus),
        .imm   (imm)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rs1        (instr[19:15]),
        .rs2        (instr[24:20]),
        .rd         (wb_rd),
        .we         (instr_valid & ctrl_bus.reg_write),
        .ctrl       (ctrl_bus),
        .alu_result (alu_result),
        .load_data  (load_data),
        .pc_plus4   (pc_plus4),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .wb_value   (wb_data)
    );

    alu u_alu (
        .ctrl         (ctrl_bus),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .imm          (imm),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    data_ram #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_data_ram (
        .clk         (clk),
        .instr_valid (instr_valid),
        .ctrl        (ctrl_bus),
        .addr        (alu_result),
        .store_data  (rs2_data),
        .load_data   (load_data)
    );

    pc_unit u_pc_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .ctrl         (ctrl_bus),
        .imm          (imm),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .pc           (pc),
        .pc_plus4     (pc_plus4)
    );

endmodule

`default_nettype wire

// File: verification/core_assertions.sv
`default_nettype none

module core_assertions (
    input wire logic        clk,
    input wire logic        rst_n,
    input wire logic        instr_valid,
    input wire logic [31:0] pc,
    input wire logic        wb_valid,
    input wire logic [4:0]  wb_rd
);
    timeunit 1ns;
    timeprecision 100ps;

    int error_count = 0;    // Failed assertions so far

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else begin
            $error("pc is not word aligned");
            error_count++;
        end

    // A write-back is only reported for a presented instruction
    wb_needs_instr: assert property (@(posedge clk) disable iff (!rst_n)
        !instr_valid |-> !wb_valid)
        else begin
            $error("wb_valid high without instr_valid");
            error_count++;
        end

    wb_not_x0: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_rd != 5'd0)
        else begin
            $error("wb_valid high with wb_rd zero");
            error_count++;
        end

endmodule

bind riscv_core core_assertions u_core_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .pc          (pc),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd)
);

`default_nettype wire

// File: verification/core_tb.sv
`default_nettype none

module core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [6:0] OPC_IMM   = 7'h13;
    localparam logic [6:0] OPC_LOAD  = 7'h03;
    localparam logic [6:0] OPC_LUI   = 7'h37;
    localparam logic [6:0] OPC_AUIPC = 7'h17;
    localparam logic [6:0] OPC_JALR  = 7'h67;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic        instr_valid;
    wire  [31:0] pc;
    wire         wb_valid;
    wire  [4:0]  wb_rd;
    wire  [31:0] wb_data;

    string       names[$];
    logic [31:0] instrs[$];
    logic [31:0] exp_pc[$];
    logic        exp_valid[$];
    logic [4:0]  exp_rd[$];
    logic [31:0] exp_data[$];

    riscv_core #(.DMEM_WORDS(256)) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .pc          (pc),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] i_type(logic [6:0] op, logic [4:0] rd, logic [2:0] f3,
                                           logic [4:0] rs1, logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] s_type(logic [2:0] f3, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [31:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                           logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(logic [4:0] rd, logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
    endfunction

    task automatic add_row(input string name, input logic [31:0] ins, input logic [31:0] epc,
                           input logic ev, input logic [4:0] erd, input logic [31:0] ed);
        names.push_back(name);
        instrs.push_back(ins);
        exp_pc.push_back(epc);
        exp_valid.push_back(ev);
        exp_rd.push_back(erd);
        exp_data.push_back(ed);
    endtask

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h",
                                    name, expected, actual));
        end
    endtask

    // Waits until clk has moved to the given level
    task automatic wait_clk(input logic level);
        int n;
        n = 0;
        do begin
            @(clk);
            n++;
        end while (clk !== level && n < 3);
        if (clk !== level) begin
            stop_on_error("Timeout while waiting for a clock edge");
        end
    endtask

    // Failures of the bound concurrent assertions
    always @(UUT.u_core_assertions.error_count) begin
        if (UUT.u_core_assertions.error_count != 0) begin
            stop_on_error("A concurrent assertion on the core failed");
        end
    end

    task automatic build_table;
        add_row("addi_pos",  i_type(OPC_IMM, 1, 3'b000, 0, 5),        0, 1, 1, 32'h5);
        add_row("addi_neg",  i_type(OPC_IMM, 2, 3'b000, 0, -3),       4, 1, 2, 32'hFFFFFFFD);
        add_row("slti",      i_type(OPC_IMM, 3, 3'b010, 2, 1),        8, 1, 3, 32'h1);
        add_row("xori",      i_type(OPC_IMM, 4, 3'b100, 1, 15),      12, 1, 4, 32'hA);
        add_row("srai",      i_type(OPC_IMM, 5, 3'b101, 2, 32'h401), 16, 1, 5, 32'hFFFFFFFE);
        add_row("add",       r_type(7'h00, 2, 1, 3'b000, 6),         20, 1, 6, 32'h2);
        add_row("sub",       r_type(7'h20, 2, 1, 3'b000, 7),         24, 1, 7, 32'h8);
        add_row("sll",       r_type(7'h00, 6, 1, 3'b001, 8),         28, 1, 8, 32'h14);
        add_row("sltu",      r_type(7'h00, 2, 1, 3'b011, 9),         32, 1, 9, 32'h1);
        add_row("and",       r_type(7'h00, 2, 4, 3'b111, 10),        36, 1, 10, 32'h8);
        add_row("lui",       u_type(OPC_LUI, 11, 20'h12345),         40, 1, 11, 32'h12345000);
        add_row("auipc",     u_type(OPC_AUIPC, 12, 20'h00001),       44, 1, 12, 32'h102C);
        add_row("base_addr", i_type(OPC_IMM, 13, 3'b000, 0, 32'h100), 48, 1, 13, 32'h100);
        add_row("neg_byte",  i_type(OPC_IMM, 14, 3'b000, 0, -128),   52, 1, 14, 32'hFFFFFF80);
        add_row("lui_word",  u_type(OPC_LUI, 15, 20'h87654),         56, 1, 15, 32'h87654000);
        add_row("addi_word", i_type(OPC_IMM, 15, 3'b000, 15, 32'h321), 60, 1, 15, 32'h87654321);
        add_row("sw",        s_type(3'b010, 15, 13, 0),              64, 0, 0, 32'h0);
        add_row("sb",        s_type(3'b000, 14, 13, 1),              68, 0, 0, 32'h0);
        add_row("sh",        s_type(3'b001, 2, 13, 6),               72, 0, 0, 32'h0);
        add_row("lw",        i_type(OPC_LOAD, 16, 3'b010, 13, 0),    76, 1, 16, 32'h87658021);
        add_row("lb",        i_type(OPC_LOAD, 17, 3'b000, 13, 1),    80, 1, 17, 32'hFFFFFF80);
        add_row("lbu",       i_type(OPC_LOAD, 18, 3'b100, 13, 1),    84, 1, 18, 32'h80);
        add_row("lh",        i_type(OPC_LOAD, 19, 3'b001, 13, 2),    88, 1, 19, 32'hFFFF8765);
        add_row("lhu",       i_type(OPC_LOAD, 20, 3'b101, 13, 6),    92, 1, 20, 32'hFFFD);
        add_row("beq_taken", b_type(3'b000, 1, 1, 8),                96, 0, 0, 32'h0);
        add_row("bne_not",   b_type(3'b001, 1, 1, 8),               104, 0, 0, 32'h0);
        add_row("blt_taken", b_type(3'b100, 2, 1, 12),              108, 0, 0, 32'h0);
        add_row("bgeu_not",  b_type(3'b111, 1, 2, 8),               120, 0, 0, 32'h0);
        add_row("bgeu_taken", b_type(3'b111, 2, 1, 8),              124, 0, 0, 32'h0);
        add_row("jal",       j_type(22, 16),                        132, 1, 22, 32'd136);
        add_row("jalr",      i_type(OPC_JALR, 23, 3'b000, 1, 196),  148, 1, 23, 32'd152);
        add_row("write_x0",  i_type(OPC_IMM, 0, 3'b000, 1, 7),      200, 0, 0, 32'h0);
        add_row("read_x0",   r_type(7'h00, 1, 0, 3'b000, 24),       204, 1, 24, 32'h5);
    endtask

    initial begin
        rst_n       = 1'b0;
        instr       = 32'h0000_0013;
        instr_valid = 1'b0;
        build_table();

        for (int i = 0; i < 16; i++) begin
            wait_clk(1'b1);
        end
        wait_clk(1'b0);
        rst_n = 1'b1;

        foreach (instrs[i]) begin
            wait_clk(1'b0);
            instr       = instrs[i];
            instr_valid = 1'b1;
            #2;                                        // Let the combinational trace settle
            check_value({names[i], " pc"}, exp_pc[i], pc);
            check_value({names[i], " wb_valid"}, {31'b0, exp_valid[i]}, {31'b0, wb_valid});
            if (exp_valid[i]) begin
                check_value({names[i], " wb_rd"}, {27'b0, exp_rd[i]}, {27'b0, wb_rd});
                check_value({names[i], " wb_data"}, exp_data[i], wb_data);
            end
            wait_clk(1'b1);
        end

        // A writing instruction without the strobe changes nothing
        wait_clk(1'b0);
        instr       = i_type(OPC_IMM, 25, 3'b000, 0, 1);
        instr_valid = 1'b0;
        #2;
        check_value("idle wb_valid", 32'h0, {31'b0, wb_valid});
        wait_clk(1'b1);
        wait_clk(1'b0);
        check_value("idle pc", 32'd208, pc);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
verilog/rv_pkg.sv
verilog/ctrl_if.sv
verilog/control_unit.sv
verilog/imm_gen.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/data_ram.sv
verilog/pc_unit.sv
verilog/riscv_core.sv
verification/core_assertions.sv
verification/core_tb.sv
